// ==== hdl/rcc_pkg.sv ====
package rcc_pkg;

    localparam int CFG_WIDTH = 8;
    localparam int PPRE_W = 3;
    localparam int CFGR_TIMPRE_BIT = 3;

    // number of halving stages in the divider, taps 2 to 16
    localparam int DIV_STAGES = 4;

    // bit 2 set means divided, bits 1:0 pick the tap
    // codes 1 to 3 are not named and also mean divide by 1
    typedef enum logic [PPRE_W-1:0] {
        PPRE_DIV1  = 3'd0,
        PPRE_DIV2  = 3'd4,
        PPRE_DIV4  = 3'd5,
        PPRE_DIV8  = 3'd6,
        PPRE_DIV16 = 3'd7
    } ppre_code_e;

    typedef enum logic {
        REG_CFGR   = 1'b0,
        REG_STATUS = 1'b1
    } reg_addr_e;

    // packed so the value lines up with CFGR bits 3:0
    typedef struct packed {
        logic              timpre;
        logic [PPRE_W-1:0] div_sel;
    } clk_cfg_t;

    // busy lands on bit 4 of the status readback
    typedef struct packed {
        logic     busy;
        clk_cfg_t cfg;
    } clk_status_t;

endpackage

// ==== hdl/glitch_free_clk_switch.sv ====
`timescale 1ns/1ps

module glitch_free_clk_switch #(
    parameter  int CLK_NUM = 2,
    localparam int SEL_W   = (CLK_NUM > 1) ? $clog2(CLK_NUM) : 1
) (
    input  logic [CLK_NUM-1:0] clk_in,
    input  logic               reset,
    input  logic [SEL_W-1:0]   sel,
    output logic               clk_out
);

    // enable of each input after its two falling-edge stages
    logic [CLK_NUM-1:0] clk_en;
    // set when some input other than this one is still enabled
    logic [CLK_NUM-1:0] others_on;
    logic [CLK_NUM-1:0] gated_clk;

    genvar i;
    generate
        for (i = 0; i < CLK_NUM; i = i + 1) begin : g_input
            logic en_meta;
            logic en_sync;
            logic en_req;

            assign others_on[i] = |(clk_en & ~(CLK_NUM'(1) << i));

            // request only once every other input has let go
            assign en_req = (sel == SEL_W'(i)) && !others_on[i];

            // falling edge so the enable moves only while this clock is low
            always_ff @(negedge clk_in[i]) begin
                if (reset) begin
                    en_meta <= 1'b0;
                    en_sync <= 1'b0;
                end else begin
                    en_meta <= en_req;
                    en_sync <= en_meta;
                end
            end

            assign clk_en[i]    = en_sync;
            assign gated_clk[i] = clk_in[i] & en_sync;
        end
    endgenerate

    // at most one enable is high, so the OR passes whole pulses only
    assign clk_out = |gated_clk;

endmodule

// ==== hdl/rcc_cfg_regs.sv ====
`timescale 1ns/1ps

module rcc_cfg_regs (
    input  logic                              clk_in,
    input  logic                              reset,
    input  logic                              cfg_wr,
    input  logic                              cfg_rd,
    input  rcc_pkg::reg_addr_e                cfg_addr,
    input  logic [rcc_pkg::CFG_WIDTH-1:0]     cfg_wdata,
    input  rcc_pkg::clk_status_t              status,
    output rcc_pkg::clk_cfg_t                 cfg,
    output logic                              cfg_changed,
    output logic [rcc_pkg::CFG_WIDTH-1:0]     cfg_rdata
);

    localparam int CFG_BITS = $bits(rcc_pkg::clk_cfg_t);
    localparam int STATUS_BITS = $bits(rcc_pkg::clk_status_t);

    rcc_pkg::clk_cfg_t                 wr_cfg;
    logic                              cfgr_wr;
    logic [rcc_pkg::CFG_WIDTH-1:0]     cfgr_word;
    logic [rcc_pkg::CFG_WIDTH-1:0]     status_word;

    // pick the CFGR fields out of the write data, upper bits are dropped
    assign wr_cfg.div_sel = cfg_wdata[rcc_pkg::PPRE_W-1:0];
    assign wr_cfg.timpre  = cfg_wdata[rcc_pkg::CFGR_TIMPRE_BIT];

    assign cfgr_wr = cfg_wr && (cfg_addr == rcc_pkg::REG_CFGR);

    // unused upper bits read as zero
    assign cfgr_word   = {{(rcc_pkg::CFG_WIDTH - CFG_BITS){1'b0}}, cfg};
    assign status_word = {{(rcc_pkg::CFG_WIDTH - STATUS_BITS){1'b0}}, status};

    // configuration store, cfg moves at the write edge
    always_ff @(posedge clk_in) begin
        if (reset) begin
            cfg <= '0;
        end else if (cfgr_wr) begin
            cfg <= wr_cfg;
        end
    end

    // one cycle pulse only when the stored value really changes
    always_ff @(posedge clk_in) begin
        if (reset) begin
            cfg_changed <= 1'b0;
        end else begin
            cfg_changed <= cfgr_wr && (wr_cfg != cfg);
        end
    end

    // registered read data, held until the next read strobe
    always_ff @(posedge clk_in) begin
        if (reset) begin
            cfg_rdata <= '0;
        end else if (cfg_rd) begin
            case (cfg_addr)
                rcc_pkg::REG_CFGR: begin
                    cfg_rdata <= cfgr_word;
                end
                rcc_pkg::REG_STATUS: begin
                    cfg_rdata <= status_word;
                end
                default: begin
                    cfg_rdata <= '0;
                end
            endcase
        end
    end

endmodule

// ==== hdl/rcc_pclk_timer_div.sv ====
`timescale 1ns/1ps

module rcc_pclk_timer_div (
    input  logic              clk_in,
    input  logic              reset,
    input  rcc_pkg::clk_cfg_t cfg,
    output logic              pclk,
    output logic              tim_ker_clk
);

    // bit n is clk_in divided by 2^(n+1)
    logic [rcc_pkg::DIV_STAGES-1:0] div_cnt = '0;

    logic pclk_pre;
    logic tim_ker_clk_pre_1;
    logic tim_ker_clk_pre_0;
    logic tim_fast_sel;
    logic tim_div_sel;

    // free running, keeps toggling through reset
    always_ff @(posedge clk_in) begin
        div_cnt <= div_cnt + 1'b1;
    end

    // timer taps are only used for the two slowest bus codes
    assign tim_div_sel  = (cfg.div_sel == rcc_pkg::PPRE_DIV8) ||
                          (cfg.div_sel == rcc_pkg::PPRE_DIV16);
    assign tim_fast_sel = (cfg.div_sel == rcc_pkg::PPRE_DIV16);

    // divide by 2 up to 16
    glitch_free_clk_switch #(
        .CLK_NUM (4)
    ) u_sw_pclk_pre (
        .clk_in  (div_cnt),
        .reset   (reset),
        .sel     (cfg.div_sel[1:0]),
        .clk_out (pclk_pre)
    );

    glitch_free_clk_switch #(
        .CLK_NUM (2)
    ) u_sw_pclk (
        .clk_in  ({pclk_pre, clk_in}),
        .reset   (reset),
        .sel     (cfg.div_sel[2]),
        .clk_out (pclk)
    );

    // div 2 for code 6, div 4 for code 7
    glitch_free_clk_switch #(
        .CLK_NUM (2)
    ) u_sw_tim_pre_1 (
        .clk_in  (div_cnt[1:0]),
        .reset   (reset),
        .sel     (tim_fast_sel),
        .clk_out (tim_ker_clk_pre_1)
    );

    glitch_free_clk_switch #(
        .CLK_NUM (2)
    ) u_sw_tim_pre_0 (
        .clk_in  ({tim_ker_clk_pre_1, clk_in}),
        .reset   (reset),
        .sel     (tim_div_sel),
        .clk_out (tim_ker_clk_pre_0)
    );

    // timpre low lets the timer follow pclk
    glitch_free_clk_switch #(
        .CLK_NUM (2)
    ) u_sw_tim_ker (
        .clk_in  ({tim_ker_clk_pre_0, pclk}),
        .reset   (reset),
        .sel     (cfg.timpre),
        .clk_out (tim_ker_clk)
    );

endmodule

// ==== hdl/rcc_clk_status.sv ====
`timescale 1ns/1ps

module rcc_clk_status #(
    parameter int SETTLE_CYCLES = 96
) (
    input  logic                 clk_in,
    input  logic                 reset,
    input  rcc_pkg::clk_cfg_t    cfg,
    input  logic                 cfg_changed,
    output rcc_pkg::clk_status_t status,
    output logic                 busy
);

    localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

    logic [CNT_W-1:0] settle_cnt;
    logic             settle_load;

    // reset counts as a change, the switches start from nothing
    assign settle_load = reset || cfg_changed;

    // a change while still settling restarts the full interval
    always_ff @(posedge clk_in) begin
        if (settle_load) begin
            settle_cnt <= CNT_W'(SETTLE_CYCLES);
        end else if (settle_cnt != '0) begin
            settle_cnt <= settle_cnt - 1'b1;
        end
    end

    // high for exactly SETTLE_CYCLES cycles after the last load
    assign busy = (settle_cnt != '0);

    assign status.busy = busy;
    assign status.cfg  = cfg;

endmodule

// ==== hdl/rcc_clk_top.sv ====
`timescale 1ns/1ps

module rcc_clk_top #(
    parameter int SETTLE_CYCLES = 96
) (
    input  logic                          clk_in,
    input  logic                          reset,
    input  logic                          cfg_wr,
    input  logic                          cfg_rd,
    input  rcc_pkg::reg_addr_e            cfg_addr,
    input  logic [rcc_pkg::CFG_WIDTH-1:0] cfg_wdata,
    output logic [rcc_pkg::CFG_WIDTH-1:0] cfg_rdata,
    output logic                          pclk,
    output logic                          tim_ker_clk,
    output logic                          busy
);

    rcc_pkg::clk_cfg_t    cfg;
    rcc_pkg::clk_status_t status;
    logic                 cfg_changed;

    rcc_cfg_regs u_cfg_regs (
        .clk_in      (clk_in),
        .reset       (reset),
        .cfg_wr      (cfg_wr),
        .cfg_rd      (cfg_rd),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .status      (status),
        .cfg         (cfg),
        .cfg_changed (cfg_changed),
        .cfg_rdata   (cfg_rdata)
    );

    rcc_pclk_timer_div u_clk_div (
        .clk_in      (clk_in),
        .reset       (reset),
        .cfg         (cfg),
        .pclk        (pclk),
        .tim_ker_clk (tim_ker_clk)
    );

    // settle interval must cover the slowest switch hand-over
    rcc_clk_status #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) u_clk_status (
        .clk_in      (clk_in),
        .reset       (reset),
        .cfg         (cfg),
        .cfg_changed (cfg_changed),
        .status      (status),
        .busy        (busy)
    );

endmodule

// ==== tb/rcc_clk_checker.sv ====
`timescale 1ns/1ps

module rcc_clk_checker (
    input logic                          clk_in,
    input logic                          reset,
    input logic                          cfg_wr,
    input logic                          cfg_rd,
    input logic                          cfg_changed,
    input logic                          busy,
    input logic [rcc_pkg::CFG_WIDTH-1:0] cfg_rdata
);

    // a stored change starts the settle interval on the next cycle
    a_busy_after_change: assert property (
        @(posedge clk_in) disable iff (reset)
        cfg_changed |=> busy
    ) else $error("busy did not rise after a configuration change");

    // back to back pulses each need their own write
    a_change_needs_write: assert property (
        @(posedge clk_in) disable iff (reset)
        (cfg_changed && $past(cfg_changed)) |-> $past(cfg_wr)
    ) else $error("cfg_changed stayed high over two cycles without a write");

    // read data only moves on a read strobe
    a_rdata_held: assert property (
        @(posedge clk_in) disable iff (reset)
        (!$past(cfg_rd) && !$past(reset)) |-> $stable(cfg_rdata)
    ) else $error("cfg_rdata changed without a read strobe");

endmodule

bind rcc_clk_top rcc_clk_checker u_checker (
    .clk_in      (clk_in),
    .reset       (reset),
    .cfg_wr      (cfg_wr),
    .cfg_rd      (cfg_rd),
    .cfg_changed (cfg_changed),
    .busy        (busy),
    .cfg_rdata   (cfg_rdata)
);

// ==== tb/rcc_clk_tb.sv ====
`timescale 1ns/1ps

module rcc_clk_tb;

    localparam int  SETTLE_CYCLES = 96;
    localparam real CLK_PERIOD    = 8.0;
    localparam int  EDGE_TIMEOUT  = 256;
    localparam int  BUSY_TIMEOUT  = 4 * SETTLE_CYCLES;
    localparam int  ITERATIONS    = 12;

    logic                          clk_in;
    logic                          reset;
    logic                          cfg_wr;
    logic                          cfg_rd;
    rcc_pkg::reg_addr_e            cfg_addr;
    logic [rcc_pkg::CFG_WIDTH-1:0] cfg_wdata;
    logic [rcc_pkg::CFG_WIDTH-1:0] cfg_rdata;
    logic                          pclk;
    logic                          tim_ker_clk;
    logic                          busy;

    logic [31:0] lfsr_state;
    // expected {timpre, ppre code}
    logic [3:0]  model_cfg;
    int          error_count = 0;
    int          timeout_count = 0;
    bit          run_aborted = 1'b0;
    int unsigned pclk_edges = 0;
    int unsigned tim_edges = 0;
    realtime     pclk_stamp;
    realtime     tim_stamp;
    int          i;

    rcc_clk_top #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) uut (
        .clk_in      (clk_in),
        .reset       (reset),
        .cfg_wr      (cfg_wr),
        .cfg_rd      (cfg_rd),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .pclk        (pclk),
        .tim_ker_clk (tim_ker_clk),
        .busy        (busy)
    );

    always #4 clk_in = ~clk_in;

    // rising edges of the output clocks all line up with clk_in rising edges
    always @(posedge pclk) begin
        pclk_edges = pclk_edges + 1;
        pclk_stamp = $realtime;
    end

    always @(posedge tim_ker_clk) begin
        tim_edges = tim_edges + 1;
        tim_stamp = $realtime;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] next_bits(input int count);
        logic [31:0] value;
        int          k;
        value = '0;
        for (k = 0; k < count; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // bit 2 clear is clk_in, else 2^(bits 1:0 + 1)
    function automatic int pclk_div(input logic [2:0] code);
        if (!code[2]) begin
            return 1;
        end
        return 2 << code[1:0];
    endfunction

    function automatic int tim_div(input logic [2:0] code, input logic timpre);
        if (!timpre) begin
            return pclk_div(code);
        end
        if (code == 3'd6) begin
            return 2;
        end
        if (code == 3'd7) begin
            return 4;
        end
        return 1;
    endfunction

    task automatic report_timeout(input string what);
        timeout_count++;
        run_aborted = 1'b1;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) @(posedge clk_in);
    endtask

    task automatic write_cfgr(input logic [rcc_pkg::CFG_WIDTH-1:0] data);
        @(posedge clk_in);
        cfg_wr    <= 1'b1;
        cfg_addr  <= rcc_pkg::REG_CFGR;
        cfg_wdata <= data;
        @(posedge clk_in);
        cfg_wr    <= 1'b0;
    endtask

    task automatic read_reg(input rcc_pkg::reg_addr_e addr,
                            output logic [rcc_pkg::CFG_WIDTH-1:0] data);
        @(posedge clk_in);
        cfg_rd   <= 1'b1;
        cfg_addr <= addr;
        @(posedge clk_in);
        cfg_rd   <= 1'b0;
        @(negedge clk_in);
        data = cfg_rdata;
    endtask

    task automatic check_cfgr();
        logic [rcc_pkg::CFG_WIDTH-1:0] data;
        read_reg(rcc_pkg::REG_CFGR, data);
        assert (data == {4'b0000, model_cfg}) else begin
            error_count++;
            $display("Mismatch at %0t: CFGR read 0x%02h, expected 0x%02h",
                     $time, data, {4'b0000, model_cfg});
        end
    endtask

    task automatic wait_busy_low();
        int n;
        bit done;
        if (run_aborted) return;
        done = 1'b0;
        for (n = 0; n < BUSY_TIMEOUT && !done; n++) begin
            @(negedge clk_in);
            done = !busy;
        end
        if (!done) begin
            report_timeout("busy never fell after a configuration change");
        end
    endtask

    // starts right after the write edge, counts busy from the cycle after
    task automatic watch_settle(input bit changed, input bit busy_before);
        int high_cycles;
        int n;
        bit done;
        @(negedge clk_in);
        assert (busy == busy_before) else begin
            error_count++;
            $display("Mismatch at %0t: busy is %0b in the write cycle, expected %0b",
                     $time, busy, busy_before);
        end
        if (changed) begin
            high_cycles = 0;
            done = 1'b0;
            for (n = 0; n < BUSY_TIMEOUT && !done; n++) begin
                @(negedge clk_in);
                if (busy) begin
                    high_cycles++;
                end else begin
                    done = 1'b1;
                end
            end
            if (!done) begin
                report_timeout("busy stayed high after a configuration change");
            end else begin
                assert (high_cycles == SETTLE_CYCLES) else begin
                    error_count++;
                    $display("Mismatch at %0t: busy high for %0d cycles, expected %0d",
                             $time, high_cycles, SETTLE_CYCLES);
                end
            end
        end else begin
            for (n = 0; n < 4; n++) begin
                @(negedge clk_in);
                assert (busy == busy_before) else begin
                    error_count++;
                    $display("Mismatch at %0t: busy moved after a write of the same value",
                             $time);
                end
            end
        end
    endtask

    task automatic wait_clk_edge(input bit use_tim, output realtime stamp, output bit ok);
        int unsigned start;
        int          n;
        start = use_tim ? tim_edges : pclk_edges;
        ok = 1'b0;
        for (n = 0; n < EDGE_TIMEOUT && !ok; n++) begin
            @(negedge clk_in);
            ok = ((use_tim ? tim_edges : pclk_edges) != start);
        end
        stamp = use_tim ? tim_stamp : pclk_stamp;
        if (!ok) begin
            report_timeout(use_tim ? "tim_ker_clk stopped toggling" : "pclk stopped toggling");
        end
    endtask

    // first edges may still belong to a hand-over, so skip them
    task automatic measure_period(input bit use_tim, input int div);
        realtime prev;
        realtime now;
        realtime period;
        real     expected;
        bit      ok;
        int      k;
        if (run_aborted) return;
        expected = CLK_PERIOD * div;
        prev = 0.0;
        ok = 1'b1;
        for (k = 0; k < 7 && ok; k++) begin
            wait_clk_edge(use_tim, now, ok);
            if (ok && k >= 3) begin
                period = now - prev;
                assert ((period > expected - 0.01) && (period < expected + 0.01)) else begin
                    error_count++;
                    $display("Mismatch at %0t: %s period %0.1f ns, expected %0.1f ns",
                             $time, use_tim ? "tim_ker_clk" : "pclk", period, expected);
                end
            end
            prev = now;
        end
    endtask

    task automatic apply_random_config(input logic timpre);
        logic [31:0]                   rnd;
        logic [2:0]                    code;
        logic [3:0]                    new_cfg;
        logic [rcc_pkg::CFG_WIDTH-1:0] data;
        bit                            changed;
        if (run_aborted) return;
        rnd = next_bits(3);
        idle_cycles(int'(rnd[2:0]));
        rnd = next_bits(3);
        code = rnd[2:0];
        new_cfg = {timpre, code};
        changed = (new_cfg != model_cfg);
        model_cfg = new_cfg;
        // upper data bits are noise the register must drop
        rnd = next_bits(4);
        write_cfgr({rnd[3:0], new_cfg});
        rnd = next_bits(1);
        if (rnd[0]) begin
            read_reg(rcc_pkg::REG_STATUS, data);
            assert (data == {3'b000, changed, model_cfg}) else begin
                error_count++;
                $display("Mismatch at %0t: STATUS read 0x%02h, expected 0x%02h",
                         $time, data, {3'b000, changed, model_cfg});
            end
            wait_busy_low();
        end else begin
            watch_settle(changed, 1'b0);
        end
        if (run_aborted) return;
        check_cfgr();
        measure_period(1'b0, pclk_div(code));
        measure_period(1'b1, tim_div(code, timpre));
    endtask

    initial begin
        clk_in     = 1'b0;
        reset      = 1'b1;
        cfg_wr     = 1'b0;
        cfg_rd     = 1'b0;
        cfg_addr   = rcc_pkg::REG_CFGR;
        cfg_wdata  = '0;
        lfsr_state = 32'hab36;
        model_cfg  = 4'h0;

        repeat (3) @(posedge clk_in);
        reset <= 1'b0;

        // out of reset both clocks run at clk_in
        wait_busy_low();
        if (!run_aborted) begin
            check_cfgr();
            measure_period(1'b0, 1);
            measure_period(1'b1, 1);
        end

        for (i = 0; i < ITERATIONS && !run_aborted; i++) begin
            apply_random_config(1'b0);
        end
        for (i = 0; i < ITERATIONS && !run_aborted; i++) begin
            apply_random_config(1'b1);
        end

        // same value again must not start a settle interval
        if (!run_aborted) begin
            write_cfgr({4'b1010, model_cfg});
            watch_settle(1'b0, 1'b0);
        end

        // second change while settling restarts the count
        if (!run_aborted) begin
            model_cfg = model_cfg ^ 4'b0001;
            write_cfgr({4'b0000, model_cfg});
            idle_cycles(20);
            model_cfg = model_cfg ^ 4'b1000;
            write_cfgr({4'b0000, model_cfg});
            watch_settle(1'b1, 1'b1);
        end
        if (!run_aborted) begin
            check_cfgr();
            measure_period(1'b0, pclk_div(model_cfg[2:0]));
            measure_period(1'b1, tim_div(model_cfg[2:0], model_cfg[3]));
        end

        $display("Checks done: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/rcc_pkg.sv
hdl/glitch_free_clk_switch.sv
hdl/rcc_cfg_regs.sv
hdl/rcc_pclk_timer_div.sv
hdl/rcc_clk_status.sv
hdl/rcc_clk_top.sv
tb/rcc_clk_checker.sv
tb/rcc_clk_tb.sv

// ==== Makefile ====
TOP = rcc_clk_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
